//--- Makefile
# Verilator build of the cache testbench

VERILATOR ?= verilator
TOP       ?= dcache_tb
SEED      ?= 81683
BUILD_DIR ?= build

SOURCES := $(filter-out +%,$(shell cat project.f))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): project.f $(SOURCES)
	$(VERILATOR) --binary --timing --assert -f project.f \
		--top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

# pass or fail comes from the pass line in the output
run: $(BIN)
	@out="$$($(BIN) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(BUILD_DIR)

//--- bench/dcache_tb.sv
// directed tests; the memory holds 256 words, so every test address stays below 0x400
`timescale 1ns/100ps

module dcache_tb import dcache_pkg::*; ();

    localparam int unsigned CLK_PERIOD = 10;
    localparam int unsigned TIMEOUT    = 200;
    localparam int unsigned SEED       = 81683;
    localparam int unsigned MEM_WORDS  = 256;

    logic                  clk;
    logic                  rst_n;
    logic                  bypass;
    logic                  hit;
    wb_req_t               core_req;
    wb_rsp_t               core_rsp;
    wb_req_t               mem_req;
    wb_rsp_t               mem_rsp;
    // what memory should hold after every store
    logic [WORD_WIDTH-1:0] shadow [MEM_WORDS];
    int                    errors;
    int                    checks;

    dcache_top dcache_top_inst (
        .clk_i      (clk),
        .rst_ni     (rst_n),
        .bypass_i   (bypass),
        .core_req_i (core_req),
        .core_rsp_o (core_rsp),
        .mem_req_o  (mem_req),
        .mem_rsp_i  (mem_rsp),
        .hit_o      (hit)
    );

    wb_mem_model #(
        .MEM_WORDS (MEM_WORDS)
    ) mem_inst (
        .clk_i  (clk),
        .rst_ni (rst_n),
        .req_i  (mem_req),
        .rsp_o  (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // reference helpers
    // ----------------------------------------------------------------------
    // preload pattern depends on every bit of the byte address
    function automatic logic [31:0] fill_word(input logic [31:0] byte_addr);
        return 32'hC0DE_0000 ^ (byte_addr * 32'h0001_0003);
    endfunction

    // byte lane merge under sel
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  sel);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return shadow[addr[9:2]];
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        $display("test %s finished, %0d errors so far", name, errors);
    endtask

    // ----------------------------------------------------------------------
    // core port transfers
    // ----------------------------------------------------------------------
    // called 1 ns after an edge with the cache idle
    task automatic core_transfer(input logic we, input logic [31:0] addr,
                                 input logic [31:0] wdata, input logic [3:0] sel,
                                 output logic [31:0] rdata, output int hits,
                                 output int cycles);
        core_req.cyc = 1'b1;
        core_req.stb = 1'b1;
        core_req.we  = we;
        core_req.adr = addr;
        core_req.dat = wdata;
        core_req.sel = sel;
        cycles = 0;
        hits   = 0;
        // cycles counts edges after the request cycle
        // hits counts the cycles with hit_o high up to the ack
        do begin
            @(posedge clk);
            #1;
            cycles++;
            if (hit) begin
                hits++;
            end
        end while (!core_rsp.ack && cycles < TIMEOUT);
        if (!core_rsp.ack) begin
            errors++;
            $display("timeout at %0t: no core ack for address %h", $time, addr);
            rdata    = '0;
            core_req = '0;
        end else begin
            rdata = core_rsp.dat;
            // request stays up until the ack is taken at the next edge
            @(posedge clk);
            #1;
            core_req = '0;
        end
    endtask

    task automatic wb_read(input logic [31:0] addr, output logic [31:0] data,
                           output int hits, output int cycles);
        core_transfer(1'b0, addr, '0, 4'hF, data, hits, cycles);
    endtask

    task automatic wb_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] sel);
        logic [31:0] unused_data;
        int          hits;
        int          unused_cycles;
        core_transfer(1'b1, addr, data, sel, unused_data, hits, unused_cycles);
        check(hits, 0, "store raises no hit");
        shadow[addr[9:2]] = merge_bytes(shadow[addr[9:2]], data, sel);
    endtask

    task automatic read_expect(input logic [31:0] addr, input int exp_hits,
                               input string msg);
        logic [31:0] data;
        int          hits;
        int          cycles;
        wb_read(addr, data, hits, cycles);
        check(data, expected_word(addr), msg);
        check(hits, exp_hits, {msg, " hit pulses"});
    endtask

    task automatic check_memory(input logic [31:0] addr, input string msg);
        check(mem_inst.mem_q[addr[9:2]], expected_word(addr), msg);
    endtask

    // ----------------------------------------------------------------------
    // tests
    // ----------------------------------------------------------------------
    task automatic miss_then_hit();
        logic [31:0] data;
        int          hits;
        int          cycles;
        read_expect(32'h020, 0, "first read of a line");
        wb_read(32'h020, data, hits, cycles);
        check(data, expected_word(32'h020), "second read data");
        check(hits, 1, "second read hit pulses");
        check(cycles, 1, "hit ack latency");
        for (int w = 1; w < 4; w++) begin
            read_expect(32'h020 + 4 * w, 1, "other word of the line");
        end
        report_test("load miss then hit");
    endtask

    task automatic store_hit_through();
        read_expect(32'h030, 0, "line fill before store");
        wb_write(32'h034, 32'h1122_3344, 4'b0101);
        check_memory(32'h034, "partial store written through");
        read_expect(32'h034, 1, "read after store hit");
        report_test("store hit");
    endtask

    task automatic store_miss_no_allocate();
        wb_write(32'h0A8, 32'hDEAD_BEEF, 4'hF);
        check_memory(32'h0A8, "store miss reaches memory");
        // no allocate, so this still misses
        read_expect(32'h0A8, 0, "read after store miss");
        report_test("store miss");
    endtask

    task automatic conflict_eviction();
        // both addresses use index 5 with tags 0 and 1
        for (int r = 0; r < 3; r++) begin
            read_expect(32'h050, 0, "conflict read tag 0");
            read_expect(32'h150, 0, "conflict read tag 1");
        end
        report_test("conflict eviction");
    endtask

    task automatic bypass_mode();
        logic [31:0] old_word;
        logic [31:0] data;
        int          hits;
        int          cycles;
        // line at 0x020 is cached since the first test
        old_word = expected_word(32'h024);
        bypass   = 1'b1;
        read_expect(32'h0C0, 0, "bypass read");
        read_expect(32'h024, 0, "bypass read of a cached line");
        wb_write(32'h024, 32'h0BAD_F00D, 4'hF);
        check_memory(32'h024, "bypass store");
        bypass = 1'b0;
        wb_read(32'h024, data, hits, cycles);
        check(data, old_word, "cached line keeps its old word");
        check(hits, 1, "cached line still hits");
        // a normal store brings cache and memory back in line
        wb_write(32'h024, 32'h0BAD_F00D, 4'hF);
        read_expect(32'h024, 1, "store hit after bypass");
        report_test("bypass");
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  sel;
        int          hits;
        int          cycles;
        for (int n = 0; n < 60; n++) begin
            r    = $urandom;
            // words 0 to 127 give two tags per index
            addr = {23'b0, r[6:0], 2'b00};
            data = $urandom;
            if (r[7]) begin
                sel = (r[11:8] == 4'h0) ? 4'h1 : r[11:8];
                wb_write(addr, data, sel);
            end else begin
                wb_read(addr, data, hits, cycles);
                check(data, expected_word(addr), "random read");
            end
        end
        for (int w = 0; w < MEM_WORDS; w++) begin
            check(mem_inst.mem_q[w], shadow[w], "memory image after traffic");
        end
        report_test("back-pressure");
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        $timeformat(-9, 1, " ns", 0);
        void'($urandom(SEED));
        rst_n    = 1'b0;
        bypass   = 1'b0;
        core_req = '0;
        errors   = 0;
        checks   = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i]          = fill_word(32'(i) << 2);
            mem_inst.mem_q[i]  = shadow[i];
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        miss_then_hit();
        store_hit_through();
        store_miss_no_allocate();
        conflict_eviction();
        bypass_mode();
        random_traffic();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- bench/wb_mem_model.sv
// wishbone classic slave, 0 to 3 random wait cycles before ack; addresses wrap at MEM_WORDS words
`timescale 1ns/100ps

module wb_mem_model import dcache_pkg::*; #(
    parameter int unsigned MEM_WORDS = 256
) (
    input  logic    clk_i,
    input  logic    rst_ni,
    input  wb_req_t req_i,
    output wb_rsp_t rsp_o
);

    // backdoor storage, preloaded and inspected by the testbench
    logic [WORD_WIDTH-1:0]        mem_q [MEM_WORDS];
    logic                         busy_q;
    logic [1:0]                   wait_q;
    logic [$clog2(MEM_WORDS)-1:0] word_idx;

    // word address, byte offset dropped
    assign word_idx = req_i.adr[$clog2(MEM_WORDS)+1:2];

    // ----------------------------------------------------------------------
    // transfer with random wait
    // ----------------------------------------------------------------------
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_o  <= '0;
            busy_q <= 1'b0;
            wait_q <= '0;
        end else begin
            // ack lasts one cycle
            rsp_o.ack <= 1'b0;
            // the ack cycle itself still shows the old transfer, skip it
            if (req_i.cyc && req_i.stb && !rsp_o.ack) begin
                if (!busy_q) begin
                    busy_q <= 1'b1;
                    wait_q <= 2'($urandom_range(3, 0));
                end else if (wait_q != 2'd0) begin
                    wait_q <= wait_q - 1'b1;
                end else begin
                    busy_q    <= 1'b0;
                    rsp_o.ack <= 1'b1;
                    rsp_o.dat <= mem_q[word_idx];
                    // byte lanes under sel
                    if (req_i.we) begin
                        for (int b = 0; b < SEL_WIDTH; b++) begin
                            if (req_i.sel[b]) begin
                                mem_q[word_idx][b*8 +: 8] <= req_i.dat[b*8 +: 8];
                            end
                        end
                    end
                end
            end
        end
    end

endmodule

//--- project.f
rtl/dcache_pkg.sv
rtl/cache_ram.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
bench/wb_mem_model.sv
bench/dcache_tb.sv

//--- rtl/cache_ram.sv
// single port, read data one cycle late; no reset so contents are unknown until written
`timescale 1ns/100ps

module cache_ram import dcache_pkg::*; #(
    parameter type         entry_t     = tag_entry_t,
    parameter int unsigned NUM_ENTRIES = NUM_SETS
) (
    input  logic                           clk_i,
    // one address for both read and write
    input  logic [$clog2(NUM_ENTRIES)-1:0] addr_i,
    input  logic                           we_i,
    input  entry_t                         wdata_i,
    // registered read port
    output entry_t                         rdata_o
);

    // storage array
    entry_t mem_q [NUM_ENTRIES];

    // ----------------------------------------------------------------------
    // access
    // ----------------------------------------------------------------------
    // a cycle is either a write or a read, never both
    // read register keeps its old value during a write
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[addr_i] <= wdata_i;
        end else begin
            rdata_o <= mem_q[addr_i];
        end
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    // a write to an unknown row would silently corrupt some line
    // of the array, so the controller must always hold a clean index
    known_write_addr: assert property (
        @(posedge clk_i) we_i |-> !$isunknown(addr_i)
    ) else $error("cache_ram write with unknown address");

endmodule

//--- rtl/dcache_ctrl.sv
// direct mapped write-through, no allocate on store miss; one core request in flight at a time
`timescale 1ns/100ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   bypass_i,
    // core port, cache is the slave
    input  wb_req_t                core_req_i,
    output wb_rsp_t                core_rsp_o,
    // memory port, cache is the master
    output wb_req_t                mem_req_o,
    input  wb_rsp_t                mem_rsp_i,
    // both arrays share one index
    output logic [INDEX_WIDTH-1:0] ram_index_o,
    output logic                   tag_we_o,
    output tag_entry_t             tag_wdata_o,
    input  tag_entry_t             tag_rdata_i,
    output logic                   line_we_o,
    output line_t                  line_wdata_o,
    input  line_t                  line_rdata_i,
    // one pulse per load hit
    output logic                   hit_o
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_REFILL,
        ST_LINE_WRITE,
        ST_WRITE_THROUGH,
        ST_BYPASS,
        ST_RESPOND
    } state_e;

    state_e                       state_q, state_d;
    // captured core request
    wb_req_t                      req_q;
    logic                         take_req;
    // per set valid bits
    logic [NUM_SETS-1:0]          valid_q;
    // refill word counter and assembly buffer
    logic [WORD_OFFSET_WIDTH-1:0] cnt_q;
    logic                         refill_last;
    line_t                        line_buf_q;
    line_t                        merged_line;
    // store outcome of the lookup
    logic                         store_hit_q;
    logic                         lookup_hit;
    // word returned in the respond state
    logic [WORD_WIDTH-1:0]        rsp_dat_q;
    // address views
    addr_fields_t                 core_addr;
    addr_fields_t                 req_addr;

    assign core_addr = addr_fields_t'(core_req_i.adr);
    assign req_addr  = addr_fields_t'(req_q.adr);

    // ----------------------------------------------------------------------
    // hit decision, one cycle after the speculative read
    // ----------------------------------------------------------------------
    assign lookup_hit  = valid_q[req_addr.index] && (tag_rdata_i.tag == req_addr.tag);
    assign refill_last = (cnt_q == WORD_OFFSET_WIDTH'(WORDS_PER_LINE - 1));

    // store bytes merged into the buffered line under sel
    always_comb begin
        merged_line = line_buf_q;
        for (int b = 0; b < SEL_WIDTH; b++) begin
            if (req_q.sel[b]) begin
                merged_line[req_addr.word_off][b*8 +: 8] = req_q.dat[b*8 +: 8];
            end
        end
    end

    // tag only changes on a refill
    assign tag_wdata_o  = '{tag: req_addr.tag};
    // refill writes the fetched line, a store hit writes the merged one
    assign line_wdata_o = (state_q == ST_LINE_WRITE) ? line_buf_q : merged_line;

    // ----------------------------------------------------------------------
    // FSM, next state and bus outputs
    // ----------------------------------------------------------------------
    always_comb begin
        state_d     = state_q;
        take_req    = 1'b0;
        core_rsp_o  = '0;
        mem_req_o   = '0;
        hit_o       = 1'b0;
        tag_we_o    = 1'b0;
        line_we_o   = 1'b0;
        // outside idle the arrays look at the captured index
        ram_index_o = req_addr.index;

        case (state_q)
            ST_IDLE: begin
                // speculative read with the incoming index
                ram_index_o = core_addr.index;
                if (core_req_i.cyc && core_req_i.stb) begin
                    take_req = 1'b1;
                    state_d  = bypass_i ? ST_BYPASS : ST_LOOKUP;
                end
            end

            ST_LOOKUP: begin
                if (req_q.we) begin
                    // every store goes to memory, hit or not
                    state_d = ST_WRITE_THROUGH;
                end else if (lookup_hit) begin
                    core_rsp_o.ack = 1'b1;
                    core_rsp_o.dat = line_rdata_i[req_addr.word_off];
                    hit_o          = 1'b1;
                    state_d        = ST_IDLE;
                end else begin
                    state_d = ST_REFILL;
                end
            end

            ST_REFILL: begin
                // whole line, word 0 first
                mem_req_o.cyc = 1'b1;
                mem_req_o.stb = 1'b1;
                mem_req_o.adr = {req_addr.tag, req_addr.index, cnt_q,
                                 {BYTE_OFFSET_WIDTH{1'b0}}};
                mem_req_o.sel = '1;
                if (mem_rsp_i.ack && refill_last) begin
                    state_d = ST_LINE_WRITE;
                end
            end

            ST_LINE_WRITE: begin
                tag_we_o  = 1'b1;
                line_we_o = 1'b1;
                state_d   = ST_RESPOND;
            end

            ST_WRITE_THROUGH: begin
                mem_req_o     = req_q;
                mem_req_o.cyc = 1'b1;
                mem_req_o.stb = 1'b1;
                mem_req_o.we  = 1'b1;
                if (mem_rsp_i.ack) begin
                    // array updated only when the line was present
                    line_we_o = store_hit_q;
                    state_d   = ST_RESPOND;
                end
            end

            ST_BYPASS: begin
                // one transfer as the core issued it, arrays untouched
                mem_req_o     = req_q;
                mem_req_o.cyc = 1'b1;
                mem_req_o.stb = 1'b1;
                if (mem_rsp_i.ack) begin
                    state_d = ST_RESPOND;
                end
            end

            ST_RESPOND: begin
                core_rsp_o.ack = 1'b1;
                core_rsp_o.dat = rsp_dat_q;
                state_d        = ST_IDLE;
            end

            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= ST_IDLE;
            valid_q     <= '0;
            cnt_q       <= '0;
            store_hit_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_LOOKUP) begin
                store_hit_q <= lookup_hit;
            end
            // wraps back to zero after the last word
            if (state_q == ST_REFILL && mem_rsp_i.ack) begin
                cnt_q <= cnt_q + 1'b1;
            end
            if (state_q == ST_LINE_WRITE) begin
                valid_q[req_addr.index] <= 1'b1;
            end
        end
    end

    // request and data path
    always_ff @(posedge clk_i) begin
        if (take_req) begin
            req_q <= core_req_i;
        end
        // line kept for a store merge, overwritten word by word on a refill
        if (state_q == ST_LOOKUP) begin
            line_buf_q <= line_rdata_i;
        end
        if (state_q == ST_REFILL && mem_rsp_i.ack) begin
            line_buf_q[cnt_q] <= mem_rsp_i.dat;
        end
        if (state_q == ST_LINE_WRITE) begin
            rsp_dat_q <= line_buf_q[req_addr.word_off];
        end
        if (state_q == ST_BYPASS && mem_rsp_i.ack) begin
            rsp_dat_q <= mem_rsp_i.dat;
        end
    end

    // ----------------------------------------------------------------------
    // protocol checks
    // ----------------------------------------------------------------------
    // the core holds its request until ack, so ack always meets cyc and stb
    core_ack_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        core_rsp_o.ack |-> (core_req_i.cyc && core_req_i.stb)
    ) else $error("core ack without an active request");

    mem_stb_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o.stb |-> mem_req_o.cyc
    ) else $error("mem stb outside a bus cycle");

    // a stalled memory transfer must not move
    mem_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (mem_req_o.stb && !mem_rsp_i.ack) |=> $stable(mem_req_o)
    ) else $error("mem request changed before ack");

endmodule

//--- rtl/dcache_pkg.sv
// geometry is fixed here; LINE_WIDTH and NUM_SETS must be powers of two, bytes are 8 bits wide
package dcache_pkg;

    // ----------------------------------------------------------------------
    // geometry
    // ----------------------------------------------------------------------
    // byte address and data word widths
    localparam int unsigned ADDR_WIDTH        = 32;
    localparam int unsigned WORD_WIDTH        = 32;
    localparam int unsigned SEL_WIDTH         = WORD_WIDTH / 8;
    // one line holds four words
    localparam int unsigned LINE_WIDTH        = 128;
    localparam int unsigned WORDS_PER_LINE    = LINE_WIDTH / WORD_WIDTH;
    // direct mapped, so one line per set
    localparam int unsigned NUM_SETS          = 16;
    localparam int unsigned INDEX_WIDTH       = $clog2(NUM_SETS);
    localparam int unsigned WORD_OFFSET_WIDTH = $clog2(WORDS_PER_LINE);
    localparam int unsigned BYTE_OFFSET_WIDTH = $clog2(SEL_WIDTH);
    // everything above index and offsets is tag
    localparam int unsigned TAG_WIDTH         =
        ADDR_WIDTH - INDEX_WIDTH - WORD_OFFSET_WIDTH - BYTE_OFFSET_WIDTH;

    // ----------------------------------------------------------------------
    // address split and array payloads
    // ----------------------------------------------------------------------
    // msb first: tag | index | word in line | byte in word
    typedef struct packed {
        logic [TAG_WIDTH-1:0]         tag;
        logic [INDEX_WIDTH-1:0]       index;
        logic [WORD_OFFSET_WIDTH-1:0] word_off;
        logic [BYTE_OFFSET_WIDTH-1:0] byte_off;
    } addr_fields_t;

    // tag array entry, valid bits live in the controller
    typedef struct packed {
        logic [TAG_WIDTH-1:0] tag;
    } tag_entry_t;

    // word 0 sits in the low bits of the line
    typedef logic [WORDS_PER_LINE-1:0][WORD_WIDTH-1:0] line_t;

    // ----------------------------------------------------------------------
    // wishbone classic bundles
    // ----------------------------------------------------------------------
    // master to slave
    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [ADDR_WIDTH-1:0] adr;
        logic [WORD_WIDTH-1:0] dat;
        logic [SEL_WIDTH-1:0]  sel;
    } wb_req_t;

    // slave to master, ack is a single cycle pulse
    typedef struct packed {
        logic                  ack;
        logic [WORD_WIDTH-1:0] dat;
    } wb_rsp_t;

endpackage

//--- rtl/dcache_top.sv
// cache top; both ports are wishbone classic and bypass_i must only change while idle
`timescale 1ns/100ps

module dcache_top import dcache_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_ni,
    // route everything straight to memory
    input  logic    bypass_i,
    // core port
    input  wb_req_t core_req_i,
    output wb_rsp_t core_rsp_o,
    // memory port
    output wb_req_t mem_req_o,
    input  wb_rsp_t mem_rsp_i,
    // load hit pulse for a counter
    output logic    hit_o
);

    // ----------------------------------------------------------------------
    // array wires
    // ----------------------------------------------------------------------
    logic [INDEX_WIDTH-1:0] ram_index;
    logic                   tag_we;
    tag_entry_t             tag_wdata;
    tag_entry_t             tag_rdata;
    logic                   line_we;
    line_t                  line_wdata;
    line_t                  line_rdata;

    // tag store
    cache_ram #(
        .entry_t     (tag_entry_t),
        .NUM_ENTRIES (NUM_SETS)
    ) tag_ram_inst (
        .clk_i   (clk_i),
        .addr_i  (ram_index),
        .we_i    (tag_we),
        .wdata_i (tag_wdata),
        .rdata_o (tag_rdata)
    );

    // data store, read together with the tags
    cache_ram #(
        .entry_t     (line_t),
        .NUM_ENTRIES (NUM_SETS)
    ) line_ram_inst (
        .clk_i   (clk_i),
        .addr_i  (ram_index),
        .we_i    (line_we),
        .wdata_i (line_wdata),
        .rdata_o (line_rdata)
    );

    // ----------------------------------------------------------------------
    // controller
    // ----------------------------------------------------------------------
    dcache_ctrl ctrl_inst (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .bypass_i     (bypass_i),
        .core_req_i   (core_req_i),
        .core_rsp_o   (core_rsp_o),
        .mem_req_o    (mem_req_o),
        .mem_rsp_i    (mem_rsp_i),
        .ram_index_o  (ram_index),
        .tag_we_o     (tag_we),
        .tag_wdata_o  (tag_wdata),
        .tag_rdata_i  (tag_rdata),
        .line_we_o    (line_we),
        .line_wdata_o (line_wdata),
        .line_rdata_i (line_rdata),
        .hit_o        (hit_o)
    );

endmodule
